/* source/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	// One word access. The request is a level held until ready.
	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} mem_req_t;

	// Ready lasts one cycle on the bus side.
	// On the CPU side it lasts until request drops.
	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// Everything from this address upward bypasses the cache.
	localparam logic [31:0] UNCACHEABLE_BASE = 32'h4000_0000;

	// One line holds one word, tagged with its full word address.
	typedef struct packed {
		logic [31:0] data;
		logic [31:0] tag;
	} line_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK_THEN_READ,
		FILL,
		UNCACHED_READ,
		BUS_WRITE,
		WAIT_END
	} state_t;

endpackage

`default_nettype wire

/* source/line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
	parameter type payload_t = logic [31:0],
	parameter int ADDR_BITS = 8
) (
	input wire i_clock,
	input wire i_write,
	input wire [ADDR_BITS-1:0] i_address,
	input wire payload_t i_wdata,
	output payload_t o_rdata
);

	localparam int DEPTH = 1 << ADDR_BITS;

	payload_t mem [DEPTH];

	// Contents start out as zero.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Reads every cycle and returns old data on a write to the same address.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

`default_nettype wire

/* source/data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module data_cache #(
	parameter int INDEX_BITS = 8
) (
	input wire i_clock,
	input wire i_reset,
	input wire mem_bus_pkg::mem_req_t i_cpu_req,
	output mem_bus_pkg::mem_rsp_t o_cpu_rsp,
	output mem_bus_pkg::mem_req_t o_bus_req,
	input wire mem_bus_pkg::mem_rsp_t i_bus_rsp
);

	localparam int LINES = 1 << INDEX_BITS;

	dcache_pkg::state_t state;
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;

	mem_bus_pkg::mem_req_t req_q;
	logic [31:0] rdata_q;

	logic [INDEX_BITS-1:0] index;
	logic ram_write;
	dcache_pkg::line_t ram_wdata;
	dcache_pkg::line_t line;

	logic cacheable;
	logic hit;
	logic victim_dirty;

	// While idle the RAM is fed the incoming address, so in LOOKUP
	// its output belongs to the latched request.
	assign index = (state == dcache_pkg::IDLE) ? i_cpu_req.address[INDEX_BITS+1:2]
		: req_q.address[INDEX_BITS+1:2];

	line_ram #(
		.payload_t(dcache_pkg::line_t),
		.ADDR_BITS(INDEX_BITS)
	) u_line_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(index),
		.i_wdata(ram_wdata),
		.o_rdata(line)
	);

	assign cacheable = req_q.address < dcache_pkg::UNCACHEABLE_BASE;
	assign hit = valid[index] && line.tag == req_q.address;
	assign victim_dirty = valid[index] && dirty[index] && !hit;

	// Cacheable writes land in LOOKUP; fills land with the bus ready.
	always_comb begin
		ram_write = 1'b0;
		ram_wdata.tag = req_q.address;
		ram_wdata.data = req_q.wdata;
		if (state == dcache_pkg::LOOKUP) begin
			ram_write = cacheable && req_q.rw;
		end else if (state == dcache_pkg::FILL) begin
			ram_write = i_bus_rsp.ready;
			ram_wdata.data = i_bus_rsp.rdata;
		end
	end

	assign o_cpu_rsp = '{ready: (state == dcache_pkg::WAIT_END) && i_cpu_req.request,
		rdata: rdata_q};

	always_ff @(posedge i_clock) begin
		if (state == dcache_pkg::IDLE && i_cpu_req.request) begin
			req_q <= i_cpu_req;
		end
		if (state == dcache_pkg::LOOKUP) begin
			rdata_q <= line.data;
		end else if (i_bus_rsp.ready) begin
			rdata_q <= i_bus_rsp.rdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= dcache_pkg::IDLE;
			valid <= '0;
			dirty <= '0;
			o_bus_req <= '0;
		end else begin
			case (state)
				dcache_pkg::IDLE: begin
					if (i_cpu_req.request) begin
						state <= dcache_pkg::LOOKUP;
					end
				end

				dcache_pkg::LOOKUP: begin
					if (!cacheable) begin
						// Latched request already has request set.
						o_bus_req <= req_q;
						state <= req_q.rw ? dcache_pkg::BUS_WRITE : dcache_pkg::UNCACHED_READ;
					end else if (req_q.rw) begin
						valid[index] <= 1'b1;
						dirty[index] <= 1'b1;
						if (victim_dirty) begin
							o_bus_req <= '{request: 1'b1, rw: 1'b1,
								address: line.tag, wdata: line.data};
							state <= dcache_pkg::BUS_WRITE;
						end else begin
							state <= dcache_pkg::WAIT_END;
						end
					end else if (hit) begin
						state <= dcache_pkg::WAIT_END;
					end else if (victim_dirty) begin
						o_bus_req <= '{request: 1'b1, rw: 1'b1,
							address: line.tag, wdata: line.data};
						state <= dcache_pkg::WRITEBACK_THEN_READ;
					end else begin
						o_bus_req <= '{request: 1'b1, rw: 1'b0,
							address: req_q.address, wdata: req_q.wdata};
						state <= dcache_pkg::FILL;
					end
				end

				// Request stays up while the fill follows the write-back.
				dcache_pkg::WRITEBACK_THEN_READ: begin
					if (i_bus_rsp.ready) begin
						o_bus_req.rw <= 1'b0;
						o_bus_req.address <= req_q.address;
						state <= dcache_pkg::FILL;
					end
				end

				dcache_pkg::FILL: begin
					if (i_bus_rsp.ready) begin
						o_bus_req.request <= 1'b0;
						valid[index] <= 1'b1;
						dirty[index] <= 1'b0;
						state <= dcache_pkg::WAIT_END;
					end
				end

				dcache_pkg::UNCACHED_READ, dcache_pkg::BUS_WRITE: begin
					if (i_bus_rsp.ready) begin
						o_bus_req.request <= 1'b0;
						o_bus_req.rw <= 1'b0;
						state <= dcache_pkg::WAIT_END;
					end
				end

				// Hold ready until the requester lets go.
				dcache_pkg::WAIT_END: begin
					if (!i_cpu_req.request) begin
						state <= dcache_pkg::IDLE;
					end
				end

				default: begin
					state <= dcache_pkg::IDLE;
				end
			endcase
		end
	end

	// CPU is released only once the bus transfer is over.
	a_ready_done: assert property (@(posedge i_clock) disable iff (i_reset)
		o_cpu_rsp.ready |-> !o_bus_req.request);

	a_no_bus_early: assert property (@(posedge i_clock) disable iff (i_reset)
		(state inside {dcache_pkg::IDLE, dcache_pkg::LOOKUP}) |-> !o_bus_req.request);

	a_bus_addr_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_req.request && !i_bus_rsp.ready) |=> $stable(o_bus_req.address));

endmodule

`default_nettype wire

/* source/bus_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_memory #(
	parameter int MEM_INDEX_BITS = 11,
	parameter int WAIT_STATES = 3
) (
	input wire i_clock,
	input wire i_reset,
	input wire mem_bus_pkg::mem_req_t i_bus_req,
	output mem_bus_pkg::mem_rsp_t o_bus_rsp
);

	localparam int COUNT_BITS = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

	logic [COUNT_BITS-1:0] wait_count;
	logic ready_q;
	logic cooldown;
	logic [MEM_INDEX_BITS-1:0] word_index;
	logic [31:0] ram_rdata;

	// Bit 30 keeps the uncached window apart from the cached one.
	assign word_index = {i_bus_req.address[30], i_bus_req.address[MEM_INDEX_BITS:2]};

	line_ram #(
		.payload_t(logic [31:0]),
		.ADDR_BITS(MEM_INDEX_BITS)
	) u_line_ram (
		.i_clock(i_clock),
		.i_write(ready_q && i_bus_req.rw),
		.i_address(word_index),
		.i_wdata(i_bus_req.wdata),
		.o_rdata(ram_rdata)
	);

	// Ready comes WAIT_STATES cycles after request, then one idle cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			ready_q <= 1'b0;
			cooldown <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			cooldown <= ready_q;
			if (ready_q || cooldown) begin
				wait_count <= '0;
			end else if (i_bus_req.request) begin
				if (wait_count == COUNT_BITS'(WAIT_STATES - 1)) begin
					ready_q <= 1'b1;
				end else begin
					wait_count <= wait_count + 1'b1;
				end
			end
		end
	end

	assign o_bus_rsp = '{ready: ready_q, rdata: ram_rdata};

	a_ready_in_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_rsp.ready |-> i_bus_req.request);

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int INDEX_BITS = 8,
	parameter int MEM_INDEX_BITS = 11,
	parameter int WAIT_STATES = 3
) (
	input wire i_clock,
	input wire i_reset,
	input wire mem_bus_pkg::mem_req_t i_cpu_req,
	output mem_bus_pkg::mem_rsp_t o_cpu_rsp
);

	mem_bus_pkg::mem_req_t bus_req;
	mem_bus_pkg::mem_rsp_t bus_rsp;

	data_cache #(
		.INDEX_BITS(INDEX_BITS)
	) u_data_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cpu_req(i_cpu_req),
		.o_cpu_rsp(o_cpu_rsp),
		.o_bus_req(bus_req),
		.i_bus_rsp(bus_rsp)
	);

	bus_memory #(
		.MEM_INDEX_BITS(MEM_INDEX_BITS),
		.WAIT_STATES(WAIT_STATES)
	) u_bus_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_req(bus_req),
		.o_bus_rsp(bus_rsp)
	);

endmodule

`default_nettype wire

/* test/tb_dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

	localparam int INDEX_BITS = 8;
	localparam int MEM_INDEX_BITS = 11;
	localparam int WAIT_STATES = 3;
	localparam int LINES = 1 << INDEX_BITS;

	localparam int CLOCK_PERIOD = 8;
	localparam int NUM_ACCESSES = 2000;
	localparam int DIRECTED_ACCESSES = 12;
	localparam int POOL_SIZE = 32;
	localparam int CYCLE_LIMIT = 4 * WAIT_STATES + 12;
	localparam int WATCHDOG_NS =
		(NUM_ACCESSES + DIRECTED_ACCESSES) * CYCLE_LIMIT * CLOCK_PERIOD + 20 * CLOCK_PERIOD;
	localparam logic [31:0] SEED = 32'h09218c40;

	logic clock = 1'b0;
	logic reset;
	mem_bus_pkg::mem_req_t cpu_req;
	mem_bus_pkg::mem_rsp_t cpu_rsp;

	int error_count = 0;
	int access_count = 0;

	// Reference memory. Words never written read as zero.
	logic [31:0] model_mem [logic [31:0]];

	// Expected cache contents for predicting latency.
	logic [31:0] model_tag [LINES];
	logic model_valid [LINES];
	logic model_dirty [LINES];

	logic [31:0] pool [POOL_SIZE];

	dcache_top #(
		.INDEX_BITS(INDEX_BITS),
		.MEM_INDEX_BITS(MEM_INDEX_BITS),
		.WAIT_STATES(WAIT_STATES)
	) u_dcache_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_cpu_req(cpu_req),
		.o_cpu_rsp(cpu_rsp)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s: got %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic finish_run();
		$display("Closing report: %0d accesses, %0d errors", access_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic clear_model();
		for (int i = 0; i < LINES; i++) begin
			model_tag[i] = '0;
			model_valid[i] = 1'b0;
			model_dirty[i] = 1'b0;
		end
	endtask

	// Each index gets four addresses inside the first 4 KB so memory never aliases.
	task automatic build_pool();
		for (int j = 0; j < POOL_SIZE; j++) begin
			pool[j] = 32'(((j % 4) << 10) | ((((j / 4) * 37) % LINES) << 2));
		end
	endtask

	// Cycles from request to ready, following the latency table of the cache.
	task automatic predict_latency(input logic rw, input logic [31:0] address,
		output int min_cycles, output int max_cycles);
		int idx;
		logic hit;
		logic victim_dirty;
		if (address >= dcache_pkg::UNCACHEABLE_BASE) begin
			min_cycles = WAIT_STATES + 3;
			max_cycles = WAIT_STATES + 3;
		end else begin
			idx = int'(address[INDEX_BITS+1:2]);
			hit = model_valid[idx] && model_tag[idx] == address;
			victim_dirty = model_valid[idx] && model_dirty[idx] && !hit;
			if (rw) begin
				min_cycles = victim_dirty ? WAIT_STATES + 3 : 2;
				max_cycles = min_cycles;
				model_dirty[idx] = 1'b1;
			end else if (hit) begin
				min_cycles = 2;
				max_cycles = 2;
			end else if (victim_dirty) begin
				// Write-back plus fill.
				min_cycles = WAIT_STATES + 4;
				max_cycles = 2 * (WAIT_STATES + 3);
				model_dirty[idx] = 1'b0;
			end else begin
				min_cycles = WAIT_STATES + 3;
				max_cycles = WAIT_STATES + 3;
				model_dirty[idx] = 1'b0;
			end
			model_valid[idx] = 1'b1;
			model_tag[idx] = address;
		end
	endtask

	// One full handshake. Called and returning on a falling edge.
	task automatic do_access(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata);
		int min_cycles;
		int max_cycles;
		int cycles;
		int hold;
		logic [31:0] expected;
		logic [31:0] held_rdata;
		predict_latency(rw, address, min_cycles, max_cycles);
		check_value(32'(cpu_rsp.ready), 32'd0, "ready high before request");
		cpu_req = '{request: 1'b1, rw: rw, address: address, wdata: wdata};
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!cpu_rsp.ready);
		check_value(32'(cycles >= min_cycles && cycles <= max_cycles), 32'd1,
			$sformatf("latency of %0d cycles at %h", cycles, address));
		if (rw) begin
			model_mem[address] = wdata;
		end else begin
			expected = model_mem.exists(address) ? model_mem[address] : 32'd0;
			check_value(cpu_rsp.rdata, expected, $sformatf("read data at %h", address));
		end
		held_rdata = cpu_rsp.rdata;
		hold = int'($urandom % 4);
		repeat (hold) begin
			@(negedge clock);
			check_value(32'(cpu_rsp.ready), 32'd1, "ready dropped during hold");
			if (!rw) begin
				check_value(cpu_rsp.rdata, held_rdata, "read data changed during hold");
			end
		end
		cpu_req.request = 1'b0;
		@(negedge clock);
		check_value(32'(cpu_rsp.ready), 32'd0, "ready high after request dropped");
		access_count++;
	endtask

	// Fixed cases first. Same-index pairs force write-back and fill.
	task automatic run_directed();
		do_access(1'b0, 32'h0000_0ffc, 32'h0);
		do_access(1'b1, 32'h0000_0010, 32'h1111_1111);
		do_access(1'b1, 32'h0000_0410, 32'h2222_2222);
		do_access(1'b0, 32'h0000_0010, 32'h0);
		do_access(1'b0, 32'h0000_0410, 32'h0);
		do_access(1'b1, 32'h0000_0010, 32'h3333_3333);
		do_access(1'b0, 32'h0000_0410, 32'h0);
		do_access(1'b0, 32'h0000_0010, 32'h0);
		do_access(1'b1, 32'h4000_0008, 32'hcafe_0001);
		do_access(1'b0, 32'h4000_0008, 32'h0);
		do_access(1'b0, 32'h4000_0030, 32'h0);
		do_access(1'b0, 32'h0000_0810, 32'h0);
	endtask

	task automatic run_random();
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
		for (int n = 0; n < NUM_ACCESSES; n++) begin
			if ($urandom % 10 < 7) begin
				address = pool[$urandom % POOL_SIZE];
			end else begin
				address = dcache_pkg::UNCACHEABLE_BASE + 32'(($urandom % 16) * 4);
			end
			rw = 1'($urandom % 2);
			wdata = $urandom;
			do_access(rw, address, wdata);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		cpu_req = '0;
		clear_model();
		build_pool();
		repeat (2) @(negedge clock);
		reset = 1'b0;
		// Nothing requested yet, so ready must stay low.
		repeat (3) begin
			@(negedge clock);
			check_value(32'(cpu_rsp.ready), 32'd0, "ready high after reset");
		end
		run_directed();
		run_random();
		finish_run();
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
		error_count++;
		finish_run();
	end

endmodule

`default_nettype wire

/* compile.f */
source/mem_bus_pkg.sv
source/dcache_pkg.sv
source/line_ram.sv
source/data_cache.sv
source/bus_memory.sv
source/dcache_top.sv
test/tb_dcache_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into a log and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_dcache_top \
	-Mdir "$BUILD_DIR" \
	-f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_dcache_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test failed" "$LOG_FILE"; then
	exit 1
fi
exit 0
